/* all.f */
logic/cpu_pkg.sv
logic/regfile.sv
logic/if_stage.sv
logic/id_stage.sv
logic/ex_stage.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/cpu.sv
tests/cpu_tb.sv

/* logic/cpu.sv */
// top level of the five-stage core joining the stages and register file to the memory ports
`timescale 1ns/100ps

module cpu (
  input  logic                               clock,
  input  logic                               reset,
  output logic                               if_rw_valid,
  input  logic                               if_rw_ready,
  input  logic [cpu_pkg::xlen-1:0]           if_r_data,
  output logic [cpu_pkg::xlen-1:0]           if_rw_addr,
  output logic                               mem_rw_valid,
  input  logic                               mem_rw_ready,
  output logic                               mem_rw_req,
  input  logic [cpu_pkg::xlen-1:0]           mem_r_data,
  output logic [cpu_pkg::xlen-1:0]           mem_w_data,
  output logic [cpu_pkg::xlen-1:0]           mem_rw_addr,
  output logic                               commit_valid,
  output logic [cpu_pkg::xlen-1:0]           commit_pc,
  output logic                               commit_wen,
  output logic [cpu_pkg::reg_addr_width-1:0] commit_rd,
  output logic [cpu_pkg::xlen-1:0]           commit_wdata
);
  import cpu_pkg::*;

  // fetch to decode
  logic                      if_to_id_valid, id_allowin;
  logic [xlen-1:0]           if_to_id_pc, if_to_id_inst;

  // redirect from execute
  logic                      redirect_valid;
  logic [xlen-1:0]           redirect_pc;

  // register file and interlock
  logic [reg_addr_width-1:0] rs1_addr, rs2_addr;
  logic [xlen-1:0]           rs1_data, rs2_data;
  logic [reg_addr_width-1:0] ex_dest, mem_dest, wb_dest;
  logic                      wr_ena;
  logic [reg_addr_width-1:0] wr_addr;
  logic [xlen-1:0]           wr_data;

  // decode to execute
  logic                      id_to_ex_valid, ex_allowin;
  logic [xlen-1:0]           id_to_ex_pc, id_to_ex_a, id_to_ex_b;
  logic [xlen-1:0]           id_to_ex_store_data, id_to_ex_imm;
  logic [reg_addr_width-1:0] id_to_ex_dest;
  alu_op_t                   id_to_ex_alu_op;
  kind_t                     id_to_ex_kind;

  // execute to memory
  logic                      ex_to_mem_valid, mem_allowin;
  logic [xlen-1:0]           ex_to_mem_pc, ex_to_mem_result, ex_to_mem_store_data;
  logic [reg_addr_width-1:0] ex_to_mem_dest;
  kind_t                     ex_to_mem_kind;

  // memory to writeback
  logic                      mem_to_wb_valid, wb_allowin;
  logic [xlen-1:0]           mem_to_wb_pc, mem_to_wb_wdata;
  logic [reg_addr_width-1:0] mem_to_wb_dest;

  // port names match the nets above
  if_stage  i_if_stage  (.*);
  id_stage  i_id_stage  (.*);
  ex_stage  i_ex_stage  (.*);
  mem_stage i_mem_stage (.*);
  wb_stage  i_wb_stage  (.*);
  regfile   i_regfile   (.*);

endmodule

/* logic/cpu_pkg.sv */
// shared widths, opcodes and operation types, imported by every module of the core
package cpu_pkg;

  localparam int xlen           = 32;
  localparam int reg_addr_width = 5;

  // first fetch address after reset
  localparam logic [xlen-1:0] pc_start = 32'h0000_0000;

  // rv32i major opcodes of the supported subset
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;

  // alu operations where pass_b carries the lui immediate through
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_pass_b
  } alu_op_t;

  // instruction class seen by execute and memory
  typedef enum logic [2:0] {
    kind_alu,
    kind_load,
    kind_store,
    kind_beq,
    kind_bne,
    kind_jal
  } kind_t;

endpackage

/* logic/ex_stage.sv */
// execute stage with the alu, branch and jal resolution, and the execute-to-memory register
`timescale 1ns/100ps

module ex_stage (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               id_to_ex_valid,
  input  logic [cpu_pkg::xlen-1:0]           id_to_ex_pc,
  input  cpu_pkg::alu_op_t                   id_to_ex_alu_op,
  input  logic [cpu_pkg::xlen-1:0]           id_to_ex_a,
  input  logic [cpu_pkg::xlen-1:0]           id_to_ex_b,
  input  logic [cpu_pkg::xlen-1:0]           id_to_ex_store_data,
  input  logic [cpu_pkg::xlen-1:0]           id_to_ex_imm,
  input  logic [cpu_pkg::reg_addr_width-1:0] id_to_ex_dest,
  input  cpu_pkg::kind_t                     id_to_ex_kind,
  output logic                               ex_allowin,
  output logic [cpu_pkg::reg_addr_width-1:0] ex_dest,
  output logic                               redirect_valid,
  output logic [cpu_pkg::xlen-1:0]           redirect_pc,
  output logic                               ex_to_mem_valid,
  output logic [cpu_pkg::xlen-1:0]           ex_to_mem_pc,
  output logic [cpu_pkg::xlen-1:0]           ex_to_mem_result,
  output logic [cpu_pkg::xlen-1:0]           ex_to_mem_store_data,
  output logic [cpu_pkg::reg_addr_width-1:0] ex_to_mem_dest,
  output cpu_pkg::kind_t                     ex_to_mem_kind,
  input  logic                               mem_allowin
);
  import cpu_pkg::*;

  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] result;
  logic            taken;

  always_comb begin
    case (id_to_ex_alu_op)
      alu_sub:    alu_result = id_to_ex_a - id_to_ex_b;
      alu_and:    alu_result = id_to_ex_a & id_to_ex_b;
      alu_or:     alu_result = id_to_ex_a | id_to_ex_b;
      alu_xor:    alu_result = id_to_ex_a ^ id_to_ex_b;
      alu_pass_b: alu_result = id_to_ex_b;
      default:    alu_result = id_to_ex_a + id_to_ex_b;
    endcase
  end

  // jal links pc+4 while loads and stores take the alu sum as address
  assign result = (id_to_ex_kind == kind_jal) ? id_to_ex_pc + xlen'(4) : alu_result;

  assign taken = (id_to_ex_kind == kind_beq && id_to_ex_a == id_to_ex_b) ||
                 (id_to_ex_kind == kind_bne && id_to_ex_a != id_to_ex_b) ||
                 (id_to_ex_kind == kind_jal);

  // redirect fires in the cycle the branch moves on to memory
  assign redirect_valid = id_to_ex_valid && mem_allowin && taken;
  assign redirect_pc    = id_to_ex_pc + id_to_ex_imm;

  assign ex_allowin = !id_to_ex_valid || mem_allowin;
  assign ex_dest    = id_to_ex_valid ? id_to_ex_dest : '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_to_mem_valid <= 1'b0;
    end else if (mem_allowin) begin
      ex_to_mem_valid <= id_to_ex_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_allowin) begin
      ex_to_mem_pc         <= id_to_ex_pc;
      ex_to_mem_result     <= result;
      ex_to_mem_store_data <= id_to_ex_store_data;
      ex_to_mem_dest       <= id_to_ex_dest;
      ex_to_mem_kind       <= id_to_ex_kind;
    end
  end

endmodule

/* logic/id_stage.sv */
// decode stage with operand select, load-use and raw interlock, and the decode-to-execute register
`timescale 1ns/100ps

module id_stage (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               if_to_id_valid,
  input  logic [cpu_pkg::xlen-1:0]           if_to_id_pc,
  input  logic [cpu_pkg::xlen-1:0]           if_to_id_inst,
  output logic                               id_allowin,
  output logic [cpu_pkg::reg_addr_width-1:0] rs1_addr,
  output logic [cpu_pkg::reg_addr_width-1:0] rs2_addr,
  input  logic [cpu_pkg::xlen-1:0]           rs1_data,
  input  logic [cpu_pkg::xlen-1:0]           rs2_data,
  input  logic [cpu_pkg::reg_addr_width-1:0] ex_dest,
  input  logic [cpu_pkg::reg_addr_width-1:0] mem_dest,
  input  logic [cpu_pkg::reg_addr_width-1:0] wb_dest,
  input  logic                               redirect_valid,
  output logic                               id_to_ex_valid,
  output logic [cpu_pkg::xlen-1:0]           id_to_ex_pc,
  output cpu_pkg::alu_op_t                   id_to_ex_alu_op,
  output logic [cpu_pkg::xlen-1:0]           id_to_ex_a,
  output logic [cpu_pkg::xlen-1:0]           id_to_ex_b,
  output logic [cpu_pkg::xlen-1:0]           id_to_ex_store_data,
  output logic [cpu_pkg::xlen-1:0]           id_to_ex_imm,
  output logic [cpu_pkg::reg_addr_width-1:0] id_to_ex_dest,
  output cpu_pkg::kind_t                     id_to_ex_kind,
  input  logic                               ex_allowin
);
  import cpu_pkg::*;

  logic [6:0]                opcode;
  logic [2:0]                funct3;
  logic [reg_addr_width-1:0] rd;
  logic [xlen-1:0]           imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_t                   alu_op;
  kind_t                     kind;
  logic [reg_addr_width-1:0] dest;
  logic [xlen-1:0]           op_b;
  logic [xlen-1:0]           imm;
  logic                      use_rs1, use_rs2;
  logic                      rs1_hit, rs2_hit, stall;

  assign opcode   = if_to_id_inst[6:0];
  assign rd       = if_to_id_inst[11:7];
  assign funct3   = if_to_id_inst[14:12];
  assign rs1_addr = if_to_id_inst[19:15];
  assign rs2_addr = if_to_id_inst[24:20];

  assign imm_i = {{20{if_to_id_inst[31]}}, if_to_id_inst[31:20]};
  assign imm_s = {{20{if_to_id_inst[31]}}, if_to_id_inst[31:25], if_to_id_inst[11:7]};
  assign imm_b = {{19{if_to_id_inst[31]}}, if_to_id_inst[31], if_to_id_inst[7],
                  if_to_id_inst[30:25], if_to_id_inst[11:8], 1'b0};
  assign imm_u = {if_to_id_inst[31:12], 12'b0};
  assign imm_j = {{11{if_to_id_inst[31]}}, if_to_id_inst[31], if_to_id_inst[19:12],
                  if_to_id_inst[20], if_to_id_inst[30:21], 1'b0};

  // anything unrecognised keeps the defaults of an addi to x0
  always_comb begin
    alu_op  = alu_add;
    kind    = kind_alu;
    dest    = '0;
    op_b    = imm_i;
    imm     = imm_b;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (opcode)
      op_imm: begin
        use_rs1 = 1'b1;
        if (funct3 == 3'b000) begin
          dest = rd;
        end
      end
      op_reg: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        op_b    = rs2_data;
        if (if_to_id_inst[31:25] == 7'h00) begin
          dest = rd;
          case (funct3)
            3'b000:  alu_op = alu_add;
            3'b100:  alu_op = alu_xor;
            3'b110:  alu_op = alu_or;
            3'b111:  alu_op = alu_and;
            default: dest = '0;
          endcase
        end else if (if_to_id_inst[31:25] == 7'h20 && funct3 == 3'b000) begin
          alu_op = alu_sub;
          dest   = rd;
        end
      end
      op_lui: begin
        alu_op = alu_pass_b;
        op_b   = imm_u;
        dest   = rd;
      end
      op_load: begin
        use_rs1 = 1'b1;
        if (funct3 == 3'b010) begin
          kind = kind_load;
          dest = rd;
        end
      end
      op_store: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        op_b    = imm_s;
        if (funct3 == 3'b010) begin
          kind = kind_store;
        end
      end
      op_branch: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        op_b    = rs2_data;
        if (funct3 == 3'b000) begin
          kind = kind_beq;
        end else if (funct3 == 3'b001) begin
          kind = kind_bne;
        end
      end
      op_jal: begin
        kind = kind_jal;
        imm  = imm_j;
        dest = rd;
      end
      default: ;
    endcase
  end

  // wait until every producer of a source has reached the register file
  assign rs1_hit = use_rs1 && rs1_addr != '0 &&
                   (rs1_addr == ex_dest || rs1_addr == mem_dest || rs1_addr == wb_dest);
  assign rs2_hit = use_rs2 && rs2_addr != '0 &&
                   (rs2_addr == ex_dest || rs2_addr == mem_dest || rs2_addr == wb_dest);
  assign stall = if_to_id_valid && (rs1_hit || rs2_hit);

  assign id_allowin = !if_to_id_valid || (!stall && ex_allowin);

  always_ff @(posedge clock) begin
    if (reset) begin
      id_to_ex_valid <= 1'b0;
    end else if (redirect_valid) begin
      id_to_ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      id_to_ex_valid <= if_to_id_valid && !stall;
    end
  end

  always_ff @(posedge clock) begin
    if (ex_allowin) begin
      id_to_ex_pc         <= if_to_id_pc;
      id_to_ex_alu_op     <= alu_op;
      id_to_ex_a          <= rs1_data;
      id_to_ex_b          <= op_b;
      id_to_ex_store_data <= rs2_data;
      id_to_ex_imm        <= imm;
      id_to_ex_dest       <= dest;
      id_to_ex_kind       <= kind;
    end
  end

endmodule

/* logic/if_stage.sv */
// fetch stage holding the pc, driving the instruction port and the fetch-to-decode register
`timescale 1ns/100ps

module if_stage (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     id_allowin,
  input  logic                     redirect_valid,
  input  logic [cpu_pkg::xlen-1:0] redirect_pc,
  output logic                     if_to_id_valid,
  output logic [cpu_pkg::xlen-1:0] if_to_id_pc,
  output logic [cpu_pkg::xlen-1:0] if_to_id_inst,
  output logic                     if_rw_valid,
  input  logic                     if_rw_ready,
  output logic [cpu_pkg::xlen-1:0] if_rw_addr,
  input  logic [cpu_pkg::xlen-1:0] if_r_data
);
  import cpu_pkg::*;

  logic [xlen-1:0] pc;
  logic            stale;
  logic            fetch_go;
  logic            accept;

  // issue only when the decode buffer is empty or drains this cycle
  assign fetch_go = !if_rw_valid && !redirect_valid && (!if_to_id_valid || id_allowin);
  // a word fetched before a redirect is dropped
  assign accept = if_rw_valid && if_rw_ready && !stale && !redirect_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc             <= pc_start;
      if_rw_valid    <= 1'b0;
      stale          <= 1'b0;
      if_to_id_valid <= 1'b0;
    end else begin
      if (fetch_go) begin
        if_rw_valid <= 1'b1;
      end else if (if_rw_ready) begin
        if_rw_valid <= 1'b0;
      end
      if (if_rw_valid && if_rw_ready) begin
        stale <= 1'b0;
      end else if (if_rw_valid && redirect_valid) begin
        stale <= 1'b1;
      end
      if (redirect_valid) begin
        pc <= redirect_pc;
      end else if (accept) begin
        pc <= pc + xlen'(4);
      end
      if (redirect_valid) begin
        if_to_id_valid <= 1'b0;
      end else if (accept) begin
        if_to_id_valid <= 1'b1;
      end else if (id_allowin) begin
        if_to_id_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_go) begin
      if_rw_addr <= pc;
    end
    if (accept) begin
      if_to_id_pc   <= if_rw_addr;
      if_to_id_inst <= if_r_data;
    end
  end

  // request address holds until the memory answers
  a_fetch_addr_stable: assert property (@(posedge clock) disable iff (reset)
    if_rw_valid && !if_rw_ready |=> if_rw_valid && $stable(if_rw_addr));

endmodule

/* logic/mem_stage.sv */
// memory stage sequencing data port requests and holding the memory-to-writeback register
`timescale 1ns/100ps

module mem_stage (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               ex_to_mem_valid,
  input  logic [cpu_pkg::xlen-1:0]           ex_to_mem_pc,
  input  logic [cpu_pkg::xlen-1:0]           ex_to_mem_result,
  input  logic [cpu_pkg::xlen-1:0]           ex_to_mem_store_data,
  input  logic [cpu_pkg::reg_addr_width-1:0] ex_to_mem_dest,
  input  cpu_pkg::kind_t                     ex_to_mem_kind,
  output logic                               mem_allowin,
  output logic [cpu_pkg::reg_addr_width-1:0] mem_dest,
  output logic                               mem_rw_valid,
  input  logic                               mem_rw_ready,
  output logic                               mem_rw_req,
  input  logic [cpu_pkg::xlen-1:0]           mem_r_data,
  output logic [cpu_pkg::xlen-1:0]           mem_w_data,
  output logic [cpu_pkg::xlen-1:0]           mem_rw_addr,
  output logic                               mem_to_wb_valid,
  output logic [cpu_pkg::xlen-1:0]           mem_to_wb_pc,
  output logic [cpu_pkg::reg_addr_width-1:0] mem_to_wb_dest,
  output logic [cpu_pkg::xlen-1:0]           mem_to_wb_wdata,
  input  logic                               wb_allowin
);
  import cpu_pkg::*;

  typedef enum logic {
    st_req,
    st_done
  } state_t;

  state_t          state;
  logic [xlen-1:0] load_data;
  logic            is_mem;
  logic            ready_go;

  assign is_mem   = ex_to_mem_kind == kind_load || ex_to_mem_kind == kind_store;
  assign ready_go = !is_mem || state == st_done;

  assign mem_allowin = !ex_to_mem_valid || (ready_go && wb_allowin);
  assign mem_dest    = ex_to_mem_valid ? ex_to_mem_dest : '0;

  // request fields come straight from the held stage register
  assign mem_rw_valid = ex_to_mem_valid && is_mem && state == st_req;
  assign mem_rw_req   = ex_to_mem_kind == kind_store;
  assign mem_rw_addr  = ex_to_mem_result;
  assign mem_w_data   = ex_to_mem_store_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_req;
    end else if (mem_rw_valid && mem_rw_ready) begin
      state <= st_done;
    end else if (state == st_done && wb_allowin) begin
      state <= st_req;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_rw_valid && mem_rw_ready) begin
      load_data <= mem_r_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_to_wb_valid <= 1'b0;
    end else if (wb_allowin) begin
      mem_to_wb_valid <= ex_to_mem_valid && ready_go;
    end
  end

  always_ff @(posedge clock) begin
    if (wb_allowin) begin
      mem_to_wb_pc    <= ex_to_mem_pc;
      mem_to_wb_dest  <= ex_to_mem_dest;
      mem_to_wb_wdata <= (ex_to_mem_kind == kind_load) ? load_data : ex_to_mem_result;
    end
  end

  // once raised, a data request stays up until the memory accepts it
  a_data_req_held: assert property (@(posedge clock) disable iff (reset)
    mem_rw_valid && !mem_rw_ready |=> mem_rw_valid);

endmodule

/* logic/regfile.sv */
// integer register file with two combinational read ports and a write-first bypass
`timescale 1ns/100ps

module regfile (
  input  logic                               clock,
  input  logic                               reset,
  input  logic [cpu_pkg::reg_addr_width-1:0] rs1_addr,
  input  logic [cpu_pkg::reg_addr_width-1:0] rs2_addr,
  output logic [cpu_pkg::xlen-1:0]           rs1_data,
  output logic [cpu_pkg::xlen-1:0]           rs2_data,
  input  logic                               wr_ena,
  input  logic [cpu_pkg::reg_addr_width-1:0] wr_addr,
  input  logic [cpu_pkg::xlen-1:0]           wr_data
);
  import cpu_pkg::*;

  logic [xlen-1:0] regs [1 << reg_addr_width];

  // x0 always reads zero and a write in the same cycle wins
  function automatic logic [xlen-1:0] read_port(input logic [reg_addr_width-1:0] addr);
    if (addr == '0) begin
      return '0;
    end else if (wr_ena && wr_addr == addr) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < (1 << reg_addr_width); i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ena && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

/* logic/wb_stage.sv */
// writeback stage registering the commit trace and driving the register file write
`timescale 1ns/100ps

module wb_stage (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               mem_to_wb_valid,
  input  logic [cpu_pkg::xlen-1:0]           mem_to_wb_pc,
  input  logic [cpu_pkg::reg_addr_width-1:0] mem_to_wb_dest,
  input  logic [cpu_pkg::xlen-1:0]           mem_to_wb_wdata,
  output logic                               wb_allowin,
  output logic [cpu_pkg::reg_addr_width-1:0] wb_dest,
  output logic                               wr_ena,
  output logic [cpu_pkg::reg_addr_width-1:0] wr_addr,
  output logic [cpu_pkg::xlen-1:0]           wr_data,
  output logic                               commit_valid,
  output logic [cpu_pkg::xlen-1:0]           commit_pc,
  output logic                               commit_wen,
  output logic [cpu_pkg::reg_addr_width-1:0] commit_rd,
  output logic [cpu_pkg::xlen-1:0]           commit_wdata
);

  // last stage never stalls
  assign wb_allowin = 1'b1;
  assign wb_dest    = mem_to_wb_valid ? mem_to_wb_dest : '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
      commit_wen   <= 1'b0;
    end else begin
      commit_valid <= mem_to_wb_valid;
      commit_wen   <= mem_to_wb_valid && mem_to_wb_dest != '0;
    end
  end

  always_ff @(posedge clock) begin
    commit_pc    <= mem_to_wb_pc;
    commit_rd    <= mem_to_wb_dest;
    commit_wdata <= mem_to_wb_wdata;
  end

  // register write lands together with the commit pulse
  assign wr_ena  = commit_wen;
  assign wr_addr = commit_rd;
  assign wr_data = commit_wdata;

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module cpu_tb -o cpu_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tests/cpu_stimulus.txt */
# I addr inst and D addr data, both hex byte addresses
# C pc wen rd(decimal) wdata, S store addr data
# program: alu chain, lui, loads and stores, branches, jal, self loop at the end
I 00000000 05a00093
I 00000004 03c00113
I 00000008 002081b3
I 0000000c 40310233
I 00000010 001272b3
I 00000014 00226333
I 00000018 0021c3b3
I 0000001c 12345437
I 00000020 67840413
I 00000024 10000493
I 00000028 0084a223
I 0000002c 0004a503
I 00000030 0044a583
I 00000034 00b50633
I 00000038 00b50463
I 0000003c 00b51463
I 00000040 00100693
I 00000044 0080076f
I 00000048 00200693
I 0000004c 00108463
I 00000050 00300693
I 00000054 00c4a423
I 00000058 fff00793
I 0000005c 0000006f
D 00000100 0badf00d
C 00000000 1 1 0000005a
C 00000004 1 2 0000003c
C 00000008 1 3 00000096
C 0000000c 1 4 ffffffa6
C 00000010 1 5 00000002
C 00000014 1 6 ffffffbe
C 00000018 1 7 000000aa
C 0000001c 1 8 12345000
C 00000020 1 8 12345678
C 00000024 1 9 00000100
C 00000028 0 0 00000000
C 0000002c 1 10 0badf00d
C 00000030 1 11 12345678
C 00000034 1 12 1de24685
C 00000038 0 0 00000000
C 0000003c 0 0 00000000
C 00000044 1 14 00000048
C 0000004c 0 0 00000000
C 00000054 0 0 00000000
C 00000058 1 15 ffffffff
C 0000005c 0 0 00000000
S 00000104 12345678
S 00000108 1de24685

/* tests/cpu_tb.sv */
// cpu testbench serving both memory ports from the stimulus file and checking the commits
`timescale 1ns/100ps

module cpu_tb;

  localparam int          clock_period   = 8;
  localparam int          reset_cycles   = 10;
  localparam int          fetch_timeout  = 20;
  localparam int          commit_timeout = 200;
  localparam int          mem_words      = 256;
  localparam logic [31:0] reset_pc       = 32'h0000_0000;

  logic        clock;
  logic        reset;
  logic        if_rw_valid;
  logic        if_rw_ready;
  logic [31:0] if_r_data;
  logic [31:0] if_rw_addr;
  logic        mem_rw_valid;
  logic        mem_rw_ready;
  logic        mem_rw_req;
  logic [31:0] mem_r_data;
  logic [31:0] mem_w_data;
  logic [31:0] mem_rw_addr;
  logic        commit_valid;
  logic [31:0] commit_pc;
  logic        commit_wen;
  logic [4:0]  commit_rd;
  logic [31:0] commit_wdata;

  logic [31:0] imem [0:mem_words-1];
  logic [31:0] dmem [0:mem_words-1];

  // expected commit trace and store sequence
  logic [31:0] exp_pc[$];
  logic [31:0] exp_wen[$];
  logic [31:0] exp_rd[$];
  logic [31:0] exp_wdata[$];
  logic [31:0] exp_store_addr[$];
  logic [31:0] exp_store_data[$];

  integer seed;
  int     if_delay;
  int     mem_delay;
  int     store_idx;
  int     store_mismatches;
  int     model_failures;
  int     mismatches;
  int     failures;

  cpu i_cpu (.*);

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // unused words still carry their own address
  task automatic fill_memories;
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = {22'b0, i[7:0], 2'b00} ^ 32'h9e37_79b9;
      dmem[i] = {22'b0, i[7:0], 2'b00} ^ 32'h5a5a_a5a5;
    end
  endtask

  task automatic load_stimulus;
    int             fd;
    int             n;
    logic           done;
    logic [7:0]     tag;
    logic [31:0]    f0, f1, f2, f3;
    logic [8*128-1:0] rest;
    done = 1'b0;
    fd = $fopen("tests/cpu_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/cpu_stimulus.txt");
      model_failures++;
      return;
    end
    while (!done) begin
      n = $fscanf(fd, " %c", tag);
      if (n != 1) begin
        done = 1'b1;
      end else if (tag == "#") begin
        n = $fgets(rest, fd);
      end else if (tag == "I" || tag == "D" || tag == "S") begin
        n = $fscanf(fd, "%h %h", f0, f1);
        if (n != 2) begin
          $display("stimulus line with tag %c is missing fields", tag);
          model_failures++;
        end else if (tag == "I") begin
          imem[f0[9:2]] = f1;
        end else if (tag == "D") begin
          dmem[f0[9:2]] = f1;
        end else begin
          exp_store_addr.push_back(f0);
          exp_store_data.push_back(f1);
        end
      end else if (tag == "C") begin
        n = $fscanf(fd, "%h %h %d %h", f0, f1, f2, f3);
        if (n != 4) begin
          $display("commit line in stimulus file is missing fields");
          model_failures++;
        end else begin
          exp_pc.push_back(f0);
          exp_wen.push_back(f1);
          exp_rd.push_back(f2);
          exp_wdata.push_back(f3);
        end
      end else begin
        $display("unknown tag %c in stimulus file", tag);
        model_failures++;
        done = 1'b1;
      end
    end
    $fclose(fd);
  endtask

  // both memory models give one ready pulse per request after 0 to 3 wait cycles
  initial begin
    seed             = 32'h6dd4ce8f;
    if_rw_ready      = 1'b0;
    if_r_data        = '0;
    mem_rw_ready     = 1'b0;
    mem_r_data       = '0;
    if_delay         = 0;
    mem_delay        = 0;
    store_idx        = 0;
    store_mismatches = 0;
    model_failures   = 0;
    fill_memories();
    load_stimulus();
    forever begin
      @(negedge clock);
      if (reset) begin
        if_rw_ready  = 1'b0;
        mem_rw_ready = 1'b0;
      end else begin
        if (if_rw_ready) begin
          if_rw_ready = 1'b0;
        end else if (if_rw_valid) begin
          if (if_delay == 0) begin
            if_rw_ready = 1'b1;
            if_r_data   = imem[if_rw_addr[9:2]];
            if_delay    = $unsigned($random(seed)) % 4;
          end else begin
            if_delay--;
          end
        end
        if (mem_rw_ready) begin
          mem_rw_ready = 1'b0;
        end else if (mem_rw_valid) begin
          if (mem_delay == 0) begin
            mem_rw_ready = 1'b1;
            mem_delay    = $unsigned($random(seed)) % 4;
            if (mem_rw_req) begin
              if (store_idx >= exp_store_addr.size()) begin
                $display("store to %h with data %h when no more stores were expected",
                         mem_rw_addr, mem_w_data);
                model_failures++;
              end else begin
                if (mem_rw_addr !== exp_store_addr[store_idx]) begin
                  $display("MISMATCH store %0d address: expected %h, actual %h",
                           store_idx, exp_store_addr[store_idx], mem_rw_addr);
                  store_mismatches++;
                end
                if (mem_w_data !== exp_store_data[store_idx]) begin
                  $display("MISMATCH store %0d data: expected %h, actual %h",
                           store_idx, exp_store_data[store_idx], mem_w_data);
                  store_mismatches++;
                end
              end
              store_idx++;
              dmem[mem_rw_addr[9:2]] = mem_w_data;
            end else begin
              mem_r_data = dmem[mem_rw_addr[9:2]];
            end
          end else begin
            mem_delay--;
          end
        end
      end
    end
  end

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
      mismatches++;
    end
  endtask

  task automatic wait_commit(output logic timed_out);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (!commit_valid && cycles < commit_timeout) begin
      @(negedge clock);
      cycles++;
    end
    timed_out = !commit_valid;
  endtask

  initial begin
    int   cycles;
    int   total;
    logic timed_out;
    reset      = 1'b1;
    mismatches = 0;
    failures   = 0;
    timed_out  = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    compare_word("reset mem_rw_valid", 32'h0, {31'b0, mem_rw_valid});
    compare_word("reset commit_valid", 32'h0, {31'b0, commit_valid});
    reset = 1'b0;

    cycles = 0;
    @(negedge clock);
    while (!if_rw_valid && cycles < fetch_timeout) begin
      @(negedge clock);
      cycles++;
    end
    if (!if_rw_valid) begin
      $display("no instruction fetch started within %0d cycles of reset", fetch_timeout);
      failures++;
    end else begin
      compare_word("reset first fetch address", reset_pc, if_rw_addr);
    end

    // commits arrive in program order and wrong-path work never shows up
    for (int i = 0; i < exp_pc.size() && !timed_out && failures == 0; i++) begin
      wait_commit(timed_out);
      if (timed_out) begin
        $display("no commit %0d within %0d cycles", i, commit_timeout);
        failures++;
      end else begin
        compare_word($sformatf("commit %0d pc", i), exp_pc[i], commit_pc);
        compare_word($sformatf("commit %0d wen", i), exp_wen[i], {31'b0, commit_wen});
        if (exp_wen[i][0]) begin
          compare_word($sformatf("commit %0d rd", i), exp_rd[i], {27'b0, commit_rd});
          compare_word($sformatf("commit %0d wdata", i), exp_wdata[i], commit_wdata);
        end
      end
    end
    if (store_idx != exp_store_addr.size()) begin
      $display("saw %0d stores but %0d were expected", store_idx, exp_store_addr.size());
      failures++;
    end

    total = mismatches + store_mismatches + failures + model_failures;
    $display("errors: %0d commit mismatches, %0d store mismatches, %0d other",
             mismatches, store_mismatches, failures + model_failures);
    if (total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
